//--- logic/bus_pkg.sv
package bus_pkg;

  localparam int XLEN = 32;
  localparam int BEAT_W = 64;

  // machine timer words, core-local
  localparam logic [31:0] MTIME_LO_ADDR = 32'h0200_bff8;
  localparam logic [31:0] MTIME_HI_ADDR = 32'h0200_bffc;

  typedef enum logic [2:0] {
    FETCH_ADDR,
    FETCH_DATA,
    LS_ADDR,
    LS_READ_DATA,
    LS_WRITE_RESP
  } arb_state_e;

  typedef struct packed {
    logic [XLEN-1:0] hi;
    logic [XLEN-1:0] lo;
  } beat_lanes_t;

  // one AXI data beat, whole or split in 32-bit lanes
  typedef union packed {
    logic [BEAT_W-1:0] dword;
    beat_lanes_t lanes;
  } beat_u;

  function automatic logic [2:0] size_from_strb(input logic [XLEN/8-1:0] strb);
    case (strb)
      4'b0001: return 3'd0;
      4'b0011: return 3'd1;
      4'b1111: return 3'd2;
      default: return 3'd0; // odd strobes fall back to byte
    endcase
  endfunction

endpackage

//--- logic/mmio_rd_if.sv
interface mmio_rd_if import bus_pkg::*; #(
  parameter int ADDR_W = 32
) ();

  logic [ADDR_W-1:0] addr;
  logic valid;
  logic [XLEN-1:0] rdata; // follows addr, no register
  logic rvalid;

  modport requester (
    output addr, valid,
    input rdata, rvalid
  );

  modport responder (
    input addr, valid,
    output rdata, rvalid
  );

endinterface

//--- logic/store_lane_align.sv
module store_lane_align import bus_pkg::*; (
  input  logic [2:0] st_offset_i,
  input  logic [XLEN-1:0] st_wdata_i,
  input  logic [XLEN/8-1:0] st_wstrb_i,
  output logic [BEAT_W-1:0] st_beat_o,
  output logic [BEAT_W/8-1:0] st_beat_strb_o,
  output logic [2:0] st_size_o
);

  logic [XLEN-1:0] word_sh;
  logic [XLEN/8-1:0] strb_sh;
  beat_u beat;

  assign word_sh = st_wdata_i << {st_offset_i[1:0], 3'b000}; // 8 bits per byte
  assign strb_sh = st_wstrb_i << st_offset_i[1:0];

  // same word in both lanes, the strobe picks the live one
  always_comb
  begin
    beat.lanes.hi = word_sh;
    beat.lanes.lo = word_sh;
  end

  assign st_beat_o = beat.dword;
  assign st_beat_strb_o = st_offset_i[2] ? {strb_sh, {(XLEN/8){1'b0}}}
                                         : {{(XLEN/8){1'b0}}, strb_sh};

  assign st_size_o = size_from_strb(st_wstrb_i); // from the unshifted request strobe

endmodule

//--- logic/clint_timer.sv
module clint_timer import bus_pkg::*; #(
  parameter logic [31:0] MTIME_BASE = MTIME_LO_ADDR
) (
  input  logic clk,
  input  logic rst,
  mmio_rd_if.responder mmio
);

  logic [2*XLEN-1:0] mtime;
  logic hi_sel;

  // offset 4 from the base is the upper word
  assign hi_sel = mmio.addr[2] ^ MTIME_BASE[2];
  assign mmio.rdata = hi_sel ? mtime[2*XLEN-1:XLEN] : mtime[XLEN-1:0];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime <= '0;
      mmio.rvalid <= 1'b0;
    end
    else
    begin
      mtime <= mtime + 1'b1; // one tick per clock
      mmio.rvalid <= mmio.valid;
    end
  end

endmodule

//--- logic/bus_arbiter.sv
module bus_arbiter import bus_pkg::*; #(
  parameter int ADDR_W = 32,
  parameter logic [31:0] MTIME_BASE = MTIME_LO_ADDR
) (
  input  logic clk,
  input  logic rst,
  // ifu
  input  logic [ADDR_W-1:0] ifu_araddr_i,
  input  logic ifu_arvalid_i,
  output logic [XLEN-1:0] ifu_rdata_o,
  output logic ifu_rvalid_o,
  // lsu load
  input  logic [ADDR_W-1:0] lsu_araddr_i,
  input  logic lsu_arvalid_i,
  input  logic [XLEN/8-1:0] lsu_rstrb_i,
  output logic [XLEN-1:0] lsu_rdata_o,
  output logic lsu_rvalid_o,
  // lsu store
  input  logic [ADDR_W-1:0] lsu_awaddr_i,
  input  logic [XLEN-1:0] lsu_wdata_i,
  input  logic [XLEN/8-1:0] lsu_wstrb_i,
  input  logic lsu_wvalid_i,
  output logic lsu_wready_o,
  // axi master
  output logic [ADDR_W-1:0] axi_araddr_o,
  output logic [2:0] axi_arsize_o,
  output logic axi_arvalid_o,
  input  logic axi_arready_i,
  input  logic [BEAT_W-1:0] axi_rdata_i,
  input  logic [1:0] axi_rresp_i,
  input  logic axi_rvalid_i,
  output logic axi_rready_o,
  output logic [ADDR_W-1:0] axi_awaddr_o,
  output logic [2:0] axi_awsize_o,
  output logic axi_awvalid_o,
  input  logic axi_awready_i,
  output logic [BEAT_W-1:0] axi_wdata_o,
  output logic [BEAT_W/8-1:0] axi_wstrb_o,
  output logic axi_wvalid_o,
  input  logic axi_wready_i,
  input  logic [1:0] axi_bresp_i,
  input  logic axi_bvalid_i,
  output logic axi_bready_o,
  // local timer
  mmio_rd_if.requester mmio,
  // store aligner
  output logic [2:0] st_offset_o,
  output logic [XLEN-1:0] st_wdata_o,
  output logic [XLEN/8-1:0] st_wstrb_o,
  input  logic [BEAT_W-1:0] st_beat_i,
  input  logic [BEAT_W/8-1:0] st_beat_strb_i,
  input  logic [2:0] st_size_i
);

  localparam logic [31:0] MTIME_HI = MTIME_BASE + (MTIME_HI_ADDR - MTIME_LO_ADDR);

  arb_state_e state;
  logic ar_hold; // fetch AR issued but not yet taken
  logic aw_done;
  logic w_done;
  logic ar_hs;
  logic aw_fin;
  logic w_fin;
  logic lsu_req;
  logic is_local;
  logic ls_rd_done;
  logic [ADDR_W-1:0] rd_addr;
  beat_u rbeat;
  logic [XLEN-1:0] rd_lane;

  assign lsu_req = lsu_arvalid_i | lsu_wvalid_i;
  assign is_local = (lsu_araddr_i == ADDR_W'(MTIME_BASE)) ||
                    (lsu_araddr_i == ADDR_W'(MTIME_HI));

  // lsu owns the read path from LS_ADDR until its data returns
  assign rd_addr = (state == LS_ADDR || state == LS_READ_DATA) ? lsu_araddr_i : ifu_araddr_i;

  // read channel
  assign axi_araddr_o = rd_addr;
  assign axi_arsize_o = (state == LS_ADDR) ? size_from_strb(lsu_rstrb_i)
                                           : size_from_strb({(XLEN/8){1'b1}});
  assign axi_arvalid_o = ((state == FETCH_ADDR) && ifu_arvalid_i && (!lsu_req || ar_hold)) ||
                         ((state == LS_ADDR) && lsu_arvalid_i && !is_local);
  assign ar_hs = axi_arvalid_o & axi_arready_i;
  assign axi_rready_o = 1'b1;

  assign rbeat.dword = axi_rdata_i;
  assign rd_lane = rd_addr[2] ? rbeat.lanes.hi : rbeat.lanes.lo;

  assign mmio.addr = rd_addr;
  assign mmio.valid = (state == LS_ADDR) && lsu_arvalid_i && is_local;

  assign ls_rd_done = is_local ? mmio.rvalid : axi_rvalid_i;

  assign ifu_rdata_o = rd_lane;
  assign ifu_rvalid_o = (state == FETCH_DATA) && axi_rvalid_i && !lsu_arvalid_i; // ifu retries
  assign lsu_rdata_o = is_local ? mmio.rdata : rd_lane;
  assign lsu_rvalid_o = (state == LS_READ_DATA) && ls_rd_done;

  // write channels, AW and W go out together
  assign st_offset_o = lsu_awaddr_i[2:0];
  assign st_wdata_o = lsu_wdata_i;
  assign st_wstrb_o = lsu_wstrb_i;

  assign axi_awaddr_o = lsu_awaddr_i;
  assign axi_awsize_o = st_size_i;
  assign axi_awvalid_o = (state == LS_ADDR) && lsu_wvalid_i && !lsu_arvalid_i && !aw_done;
  assign axi_wdata_o = st_beat_i;
  assign axi_wstrb_o = st_beat_strb_i;
  assign axi_wvalid_o = (state == LS_ADDR) && lsu_wvalid_i && !lsu_arvalid_i && !w_done;
  assign axi_bready_o = 1'b1;

  assign aw_fin = aw_done | (axi_awvalid_o & axi_awready_i);
  assign w_fin = w_done | (axi_wvalid_o & axi_wready_i);

  assign lsu_wready_o = (state == LS_WRITE_RESP) && axi_bvalid_i;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= FETCH_ADDR;
      ar_hold <= 1'b0;
      aw_done <= 1'b0;
      w_done <= 1'b0;
    end
    else
    begin
      ar_hold <= axi_arvalid_o & ~axi_arready_i;
      case (state)
        FETCH_ADDR:
        begin
          if (ar_hs)
            state <= FETCH_DATA;
          else if (lsu_req && !ar_hold)
            state <= LS_ADDR;
        end
        FETCH_DATA:
        begin
          if (axi_rvalid_i)
            state <= lsu_req ? LS_ADDR : FETCH_ADDR; // finish the fetch first
        end
        LS_ADDR:
        begin
          if (lsu_arvalid_i)
          begin
            if (is_local || ar_hs)
              state <= LS_READ_DATA;
          end
          else if (lsu_wvalid_i)
          begin
            if (aw_fin && w_fin)
            begin
              state <= LS_WRITE_RESP;
              aw_done <= 1'b0;
              w_done <= 1'b0;
            end
            else
            begin
              aw_done <= aw_fin;
              w_done <= w_fin;
            end
          end
          else
            state <= FETCH_ADDR;
        end
        LS_READ_DATA:
        begin
          if (ls_rd_done)
            state <= FETCH_ADDR;
        end
        LS_WRITE_RESP:
        begin
          if (axi_bvalid_i)
            state <= FETCH_ADDR;
        end
        default:
          state <= FETCH_ADDR;
      endcase
    end
  end

endmodule

//--- logic/bus_top.sv
module bus_top import bus_pkg::*; #(
  parameter int ADDR_W = 32,
  parameter logic [31:0] MTIME_BASE = MTIME_LO_ADDR
) (
  input  logic clk,
  input  logic rst,
  input  logic [ADDR_W-1:0] ifu_araddr_i,
  input  logic ifu_arvalid_i,
  output logic [XLEN-1:0] ifu_rdata_o,
  output logic ifu_rvalid_o,
  input  logic [ADDR_W-1:0] lsu_araddr_i,
  input  logic lsu_arvalid_i,
  input  logic [XLEN/8-1:0] lsu_rstrb_i,
  output logic [XLEN-1:0] lsu_rdata_o,
  output logic lsu_rvalid_o,
  input  logic [ADDR_W-1:0] lsu_awaddr_i,
  input  logic [XLEN-1:0] lsu_wdata_i,
  input  logic [XLEN/8-1:0] lsu_wstrb_i,
  input  logic lsu_wvalid_i,
  output logic lsu_wready_o,
  output logic [ADDR_W-1:0] axi_araddr_o,
  output logic [2:0] axi_arsize_o,
  output logic axi_arvalid_o,
  input  logic axi_arready_i,
  input  logic [BEAT_W-1:0] axi_rdata_i,
  input  logic [1:0] axi_rresp_i,
  input  logic axi_rvalid_i,
  output logic axi_rready_o,
  output logic [ADDR_W-1:0] axi_awaddr_o,
  output logic [2:0] axi_awsize_o,
  output logic axi_awvalid_o,
  input  logic axi_awready_i,
  output logic [BEAT_W-1:0] axi_wdata_o,
  output logic [BEAT_W/8-1:0] axi_wstrb_o,
  output logic axi_wvalid_o,
  input  logic axi_wready_i,
  input  logic [1:0] axi_bresp_i,
  input  logic axi_bvalid_i,
  output logic axi_bready_o
);

  logic [2:0] st_offset;
  logic [XLEN-1:0] st_wdata;
  logic [XLEN/8-1:0] st_wstrb;
  logic [BEAT_W-1:0] st_beat;
  logic [BEAT_W/8-1:0] st_beat_strb;
  logic [2:0] st_size;

  mmio_rd_if #(.ADDR_W(ADDR_W)) mmio_bus ();

  bus_arbiter #(
    .ADDR_W(ADDR_W),
    .MTIME_BASE(MTIME_BASE)
  ) u_arb (
    .clk(clk),
    .rst(rst),
    .ifu_araddr_i(ifu_araddr_i),
    .ifu_arvalid_i(ifu_arvalid_i),
    .ifu_rdata_o(ifu_rdata_o),
    .ifu_rvalid_o(ifu_rvalid_o),
    .lsu_araddr_i(lsu_araddr_i),
    .lsu_arvalid_i(lsu_arvalid_i),
    .lsu_rstrb_i(lsu_rstrb_i),
    .lsu_rdata_o(lsu_rdata_o),
    .lsu_rvalid_o(lsu_rvalid_o),
    .lsu_awaddr_i(lsu_awaddr_i),
    .lsu_wdata_i(lsu_wdata_i),
    .lsu_wstrb_i(lsu_wstrb_i),
    .lsu_wvalid_i(lsu_wvalid_i),
    .lsu_wready_o(lsu_wready_o),
    .axi_araddr_o(axi_araddr_o),
    .axi_arsize_o(axi_arsize_o),
    .axi_arvalid_o(axi_arvalid_o),
    .axi_arready_i(axi_arready_i),
    .axi_rdata_i(axi_rdata_i),
    .axi_rresp_i(axi_rresp_i),
    .axi_rvalid_i(axi_rvalid_i),
    .axi_rready_o(axi_rready_o),
    .axi_awaddr_o(axi_awaddr_o),
    .axi_awsize_o(axi_awsize_o),
    .axi_awvalid_o(axi_awvalid_o),
    .axi_awready_i(axi_awready_i),
    .axi_wdata_o(axi_wdata_o),
    .axi_wstrb_o(axi_wstrb_o),
    .axi_wvalid_o(axi_wvalid_o),
    .axi_wready_i(axi_wready_i),
    .axi_bresp_i(axi_bresp_i),
    .axi_bvalid_i(axi_bvalid_i),
    .axi_bready_o(axi_bready_o),
    .mmio(mmio_bus.requester),
    .st_offset_o(st_offset),
    .st_wdata_o(st_wdata),
    .st_wstrb_o(st_wstrb),
    .st_beat_i(st_beat),
    .st_beat_strb_i(st_beat_strb),
    .st_size_i(st_size)
  );

  store_lane_align u_align (
    .st_offset_i(st_offset),
    .st_wdata_i(st_wdata),
    .st_wstrb_i(st_wstrb),
    .st_beat_o(st_beat),
    .st_beat_strb_o(st_beat_strb),
    .st_size_o(st_size)
  );

  clint_timer #(
    .MTIME_BASE(MTIME_BASE)
  ) u_timer (
    .clk(clk),
    .rst(rst),
    .mmio(mmio_bus.responder)
  );

endmodule

//--- tb/bus_chk.sv
module bus_chk import bus_pkg::*; #(
  parameter int ADDR_W = 32,
  parameter logic [31:0] MTIME_BASE = MTIME_LO_ADDR
) (
  input logic clk,
  input logic rst,
  input arb_state_e state_i,
  input logic [ADDR_W-1:0] araddr_i,
  input logic [ADDR_W-1:0] awaddr_i,
  input logic arvalid_i,
  input logic arready_i,
  input logic awvalid_i,
  input logic awready_i,
  input logic wvalid_i,
  input logic wready_i,
  input logic rvalid_i,
  input logic bvalid_i,
  input logic [1:0] rresp_i,
  input logic [1:0] bresp_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // low and high mtime words
  localparam logic [ADDR_W-1:0] TIMER_LO = ADDR_W'(MTIME_BASE);
  localparam logic [ADDR_W-1:0] TIMER_HI = ADDR_W'(MTIME_BASE + 32'd4);

  ar_hold: assert property (@(posedge clk) disable iff (rst)
    arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
    else $error("arvalid dropped or araddr changed before arready");

  aw_hold: assert property (@(posedge clk) disable iff (rst)
    awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i))
    else $error("awvalid dropped or awaddr changed before awready");

  w_hold: assert property (@(posedge clk) disable iff (rst)
    wvalid_i && !wready_i |=> wvalid_i)
    else $error("wvalid dropped before wready");

  r_okay: assert property (@(posedge clk) disable iff (rst) rvalid_i |-> rresp_i == 2'b00)
    else $error("rresp not OKAY");

  b_okay: assert property (@(posedge clk) disable iff (rst) bvalid_i |-> bresp_i == 2'b00)
    else $error("bresp not OKAY");

  // timer loads stay off the bus
  no_ar_local: assert property (@(posedge clk) disable iff (rst)
    (state_i == LS_ADDR) && arvalid_i |-> araddr_i != TIMER_LO && araddr_i != TIMER_HI)
    else $error("AXI read issued for a timer address");

endmodule

bind bus_arbiter bus_chk #(.ADDR_W(ADDR_W), .MTIME_BASE(MTIME_BASE)) u_chk (
  .clk(clk),
  .rst(rst),
  .state_i(state),
  .araddr_i(axi_araddr_o),
  .awaddr_i(axi_awaddr_o),
  .arvalid_i(axi_arvalid_o),
  .arready_i(axi_arready_i),
  .awvalid_i(axi_awvalid_o),
  .awready_i(axi_awready_i),
  .wvalid_i(axi_wvalid_o),
  .wready_i(axi_wready_i),
  .rvalid_i(axi_rvalid_i),
  .bvalid_i(axi_bvalid_i),
  .rresp_i(axi_rresp_i),
  .bresp_i(axi_bresp_i)
);

//--- tb/bus_tb.sv
module bus_tb import bus_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT = 200;

  logic clk;
  logic rst;
  logic [31:0] ifu_araddr_i;
  logic ifu_arvalid_i;
  logic [XLEN-1:0] ifu_rdata_o;
  logic ifu_rvalid_o;
  logic [31:0] lsu_araddr_i;
  logic lsu_arvalid_i;
  logic [3:0] lsu_rstrb_i;
  logic [XLEN-1:0] lsu_rdata_o;
  logic lsu_rvalid_o;
  logic [31:0] lsu_awaddr_i;
  logic [XLEN-1:0] lsu_wdata_i;
  logic [3:0] lsu_wstrb_i;
  logic lsu_wvalid_i;
  logic lsu_wready_o;
  logic [31:0] axi_araddr_o;
  logic [2:0] axi_arsize_o;
  logic axi_arvalid_o, axi_arready_i;
  logic [63:0] axi_rdata_i;
  logic [1:0] axi_rresp_i;
  logic axi_rvalid_i, axi_rready_o;
  logic [31:0] axi_awaddr_o;
  logic [2:0] axi_awsize_o;
  logic axi_awvalid_o, axi_awready_i;
  logic [63:0] axi_wdata_o;
  logic [7:0] axi_wstrb_o;
  logic axi_wvalid_o, axi_wready_i;
  logic [1:0] axi_bresp_i;
  logic axi_bvalid_i, axi_bready_o;

  // slave memory, 16 dwords, and the expected word image
  logic [63:0] mem [16];
  logic [31:0] ref_mem [32];
  int ar_cnt, aw_cnt, w_cnt; // ready stall counters
  bit r_pend, b_pend, aw_got, w_got;
  logic [63:0] r_data, w_data, last_wdata;
  logic [31:0] aw_addr, last_awaddr;
  logic [2:0] ar_size, aw_size, last_size;
  logic [7:0] w_strb, last_wstrb;
  int ar_total, wready_total, errors, test_start, tests;

  bus_top u_bus_top (.*);

  always #4 clk = ~clk;

  function automatic logic [31:0] init_word(input int addr);
    return (addr * 32'h0001_0001) ^ 32'h5a5a_a5a5;
  endfunction

  always @(posedge clk)
  begin
    if (rst)
    begin
      r_pend = 0;
      b_pend = 0;
      aw_got = 0;
      w_got = 0;
    end
    else
    begin
      if (axi_rvalid_i)
      begin
        assert (axi_rready_o) else report_error("rready was low while rvalid was high");
        r_pend = 0;
      end
      if (axi_bvalid_i)
      begin
        assert (axi_bready_o) else report_error("bready was low while bvalid was high");
        b_pend = 0;
      end
      if (axi_arvalid_o && axi_arready_i)
      begin
        r_data = mem[axi_araddr_o[6:3]];
        ar_size = axi_arsize_o;
        r_pend = 1;
        ar_cnt = $urandom % 4;
        ar_total++;
      end
      else if (axi_arvalid_o && ar_cnt > 0)
        ar_cnt--;
      if (axi_awvalid_o && axi_awready_i)
      begin
        aw_addr = axi_awaddr_o;
        aw_size = axi_awsize_o;
        aw_got = 1;
        aw_cnt = $urandom % 4;
      end
      else if (axi_awvalid_o && aw_cnt > 0)
        aw_cnt--;
      if (axi_wvalid_o && axi_wready_i)
      begin
        w_data = axi_wdata_o;
        w_strb = axi_wstrb_o;
        w_got = 1;
        w_cnt = $urandom % 4;
      end
      else if (axi_wvalid_o && w_cnt > 0)
        w_cnt--;
      if (aw_got && w_got)
      begin
        for (int b = 0; b < 8; b++)
          if (w_strb[b])
            mem[aw_addr[6:3]][8*b +: 8] = w_data[8*b +: 8];
        last_wdata = w_data;
        last_wstrb = w_strb;
        last_size = aw_size;
        last_awaddr = aw_addr;
        b_pend = 1;
        aw_got = 0;
        w_got = 0;
      end
      if (lsu_wready_o)
        wready_total++;
    end
  end

  always @(negedge clk)
  begin
    axi_arready_i = (ar_cnt == 0);
    axi_awready_i = (aw_cnt == 0);
    axi_wready_i = (w_cnt == 0);
    axi_rvalid_i = r_pend;
    axi_rdata_i = r_data;
    axi_bvalid_i = b_pend;
  end

  task automatic expect_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp)
    else
    begin
      $display("mismatch %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("error: %s", msg);
    errors++;
  endtask

  task automatic close_test(input string name);
    tests++;
    $display("%s: %s", name, (errors == test_start) ? "pass" : "fail");
    test_start = errors;
  endtask

  task automatic ifu_fetch(input logic [31:0] addr, output logic [31:0] data);
    int n;
    bit got;
    @(negedge clk);
    ifu_araddr_i = addr;
    ifu_arvalid_i = 1'b1;
    n = 0;
    got = 0;
    while (!got && n < TIMEOUT)
    begin
      @(posedge clk);
      n++;
      got = ifu_rvalid_o;
      if (got)
        data = ifu_rdata_o;
    end
    assert (got) else report_error($sformatf("fetch at %h got no ifu_rvalid_o", addr));
    @(negedge clk);
    ifu_arvalid_i = 1'b0;
  endtask

  task automatic lsu_load(input logic [31:0] addr, input logic [3:0] rstrb,
                          output logic [31:0] data, output int lat);
    int n;
    bit got;
    @(negedge clk);
    lsu_araddr_i = addr;
    lsu_rstrb_i = rstrb;
    lsu_arvalid_i = 1'b1;
    n = 0;
    got = 0;
    while (!got && n < TIMEOUT)
    begin
      @(posedge clk);
      n++;
      got = lsu_rvalid_o;
      if (got)
        data = lsu_rdata_o;
    end
    assert (got) else report_error($sformatf("load at %h got no lsu_rvalid_o", addr));
    lat = n;
    @(negedge clk);
    lsu_arvalid_i = 1'b0;
  endtask

  task automatic lsu_store(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    int n;
    bit got;
    int off;
    @(negedge clk);
    lsu_awaddr_i = addr;
    lsu_wdata_i = data;
    lsu_wstrb_i = strb;
    lsu_wvalid_i = 1'b1;
    n = 0;
    got = 0;
    while (!got && n < TIMEOUT)
    begin
      @(posedge clk);
      n++;
      got = lsu_wready_o;
    end
    assert (got) else report_error($sformatf("store at %h got no lsu_wready_o", addr));
    @(negedge clk);
    lsu_wvalid_i = 1'b0;
    off = addr[1:0];
    // request byte k lands at byte off+k of the word
    for (int k = 0; k < 4; k++)
      if (strb[k] && off + k < 4)
        ref_mem[addr[6:2]][8*(off+k) +: 8] = data[8*k +: 8];
  endtask

  task automatic store_and_check(input string name, input logic [31:0] addr,
                                 input logic [31:0] data, input logic [3:0] strb);
    logic [31:0] sh;
    logic [3:0] s4;
    logic [7:0] s8;
    lsu_store(addr, data, strb);
    sh = data << (8 * addr[1:0]);
    s4 = strb << addr[1:0];
    s8 = addr[2] ? {s4, 4'h0} : {4'h0, s4};
    expect_eq($sformatf("%s_data", name), {sh, sh}, last_wdata);
    expect_eq($sformatf("%s_strb", name), s8, last_wstrb);
    expect_eq($sformatf("%s_size", name), (strb == 4'b0011) ? 3'd1 : 3'd0, last_size);
    expect_eq($sformatf("%s_addr", name), addr, last_awaddr);
  endtask

  task automatic fetch_lanes();
    logic [31:0] d;
    ifu_fetch(32'h18, d);
    expect_eq("fetch_lanes_lo", ref_mem[6], d);
    ifu_fetch(32'h1c, d);
    expect_eq("fetch_lanes_hi", ref_mem[7], d);
    expect_eq("fetch_lanes_size", 2, ar_size); // whole word
    close_test("fetch_lanes");
  endtask

  task automatic load_priority();
    logic [31:0] ld, fd;
    bit lsu_seen, ifu_seen;
    int n;
    @(negedge clk);
    ifu_araddr_i = 32'h24;
    ifu_arvalid_i = 1'b1;
    lsu_araddr_i = 32'h30;
    lsu_rstrb_i = 4'hf;
    lsu_arvalid_i = 1'b1;
    n = 0;
    lsu_seen = 0;
    ifu_seen = 0;
    while (!ifu_seen && n < TIMEOUT)
    begin
      @(posedge clk);
      n++;
      assert (!(ifu_rvalid_o && lsu_arvalid_i))
      else report_error("ifu_rvalid_o was high while a load was pending");
      if (ifu_rvalid_o)
      begin
        ifu_seen = 1;
        fd = ifu_rdata_o;
        assert (lsu_seen) else report_error("fetch data came back before load data");
      end
      if (lsu_rvalid_o)
      begin
        lsu_seen = 1;
        ld = lsu_rdata_o;
      end
      @(negedge clk);
      if (lsu_seen)
        lsu_arvalid_i = 1'b0;
    end
    ifu_arvalid_i = 1'b0;
    assert (ifu_seen) else report_error("fetch never completed after the load");
    expect_eq("priority_load", ref_mem[12], ld);
    expect_eq("priority_fetch", ref_mem[9], fd);
    close_test("priority");
  endtask

  task automatic store_lanes();
    logic [31:0] d;
    int lat;
    for (int off = 0; off < 4; off++)
      store_and_check($sformatf("store_lanes_b%0d", off), 32'h44 + off,
                      32'ha1b2_c3d4 ^ (off * 32'h0101_0101), 4'b0001);
    store_and_check("store_lanes_h0", 32'h50, 32'h1357_9bdf, 4'b0011);
    store_and_check("store_lanes_h2", 32'h52, 32'h2468_ace0, 4'b0011);
    lsu_load(32'h44, 4'hf, d, lat);
    expect_eq("store_lanes_merge_hi", ref_mem[17], d);
    lsu_load(32'h50, 4'b0011, d, lat);
    expect_eq("store_lanes_merge_lo", ref_mem[20], d);
    expect_eq("store_lanes_rsize", 1, ar_size); // halfword load
    close_test("store_lanes");
  endtask

  task automatic timer_reads();
    logic [31:0] t0, t1, th;
    int lat;
    int ar0;
    ar0 = ar_total;
    // one edge into LS_ADDR, one in it, rvalid on the next
    lsu_load(MTIME_LO_ADDR, 4'hf, t0, lat);
    expect_eq("timer_lat0", 3, lat);
    lsu_load(MTIME_LO_ADDR, 4'hf, t1, lat);
    expect_eq("timer_lat1", 3, lat);
    assert (t1 > t0) else report_error("mtime did not increase between two loads");
    lsu_load(MTIME_HI_ADDR, 4'hf, th, lat);
    expect_eq("timer_hi", 0, th);
    expect_eq("timer_lat_hi", 3, lat);
    expect_eq("timer_no_ar", ar0, ar_total);
    close_test("timer");
  endtask

  task automatic random_rw();
    logic [4:0] idx [20];
    logic [31:0] d;
    int lat;
    int w0;
    w0 = wready_total;
    for (int i = 0; i < 20; i++)
    begin
      idx[i] = 5'($urandom % 32);
      lsu_store({25'b0, idx[i], 2'b00}, $urandom, 4'hf);
    end
    expect_eq("random_rw_wready", 20, wready_total - w0);
    for (int i = 0; i < 20; i++)
    begin
      lsu_load({25'b0, idx[i], 2'b00}, 4'hf, d, lat);
      expect_eq($sformatf("random_rw_%0d", i), ref_mem[idx[i]], d);
    end
    close_test("random_rw");
  endtask

  initial
  begin
    void'($urandom(32'h63f7));
    clk = 0;
    rst = 1;
    ifu_araddr_i = '0;
    ifu_arvalid_i = 0;
    lsu_araddr_i = '0;
    lsu_arvalid_i = 0;
    lsu_rstrb_i = '0;
    lsu_awaddr_i = '0;
    lsu_wdata_i = '0;
    lsu_wstrb_i = '0;
    lsu_wvalid_i = 0;
    axi_arready_i = 0;
    axi_rdata_i = '0;
    axi_rresp_i = '0;
    axi_rvalid_i = 0;
    axi_awready_i = 0;
    axi_wready_i = 0;
    axi_bresp_i = '0;
    axi_bvalid_i = 0;
    r_data = '0;
    ar_cnt = $urandom % 4;
    aw_cnt = $urandom % 4;
    w_cnt = $urandom % 4;
    for (int j = 0; j < 32; j++)
    begin
      ref_mem[j] = init_word(j * 4);
      mem[j / 2][32*(j % 2) +: 32] = ref_mem[j];
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 0;
    fetch_lanes();
    load_priority();
    store_lanes();
    timer_reads();
    random_rw();
    $display("tests %0d, errors %0d", tests, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

//--- list.f
logic/bus_pkg.sv
logic/mmio_rd_if.sv
logic/store_lane_align.sv
logic/clint_timer.sv
logic/bus_arbiter.sv
logic/bus_top.sv
tb/bus_chk.sv
tb/bus_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the bus testbench with verilator, result decided from sim.log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
  -f list.f --top-module bus_tb -Mdir obj_dir &&
./obj_dir/Vbus_tb > sim.log 2>&1 || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "Test FAILED" sim.log && exit 1 || exit 0
